// File: include/cpu_defs.svh
// core sizing macros
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data word and address width
`define WORD_W 32

// architectural registers
`define REG_CNT 32

// first fetch address
`define PC_INIT 32'h0000_0000

`endif

// File: rtl/cpu_types_pkg.sv
// core types package
`default_nettype none

`include "cpu_defs.svh"

package cpu_types_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [$clog2(`REG_CNT)-1:0] regbits_t;

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_OPIMM  = 7'b0010011,
    OP_STORE  = 7'b0100011,
    OP_OP     = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_HALT   = 7'b1111111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } aluop_t;

  typedef enum logic [1:0] {
    FWD_RF,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

  typedef struct packed {
    word_t pc;
    word_t ins;
  } if_id_t;

  typedef struct packed {
    word_t    pc;
    word_t    rdat1;
    word_t    rdat2;
    word_t    imm;
    regbits_t rs1;
    regbits_t rs2;
    regbits_t rd;
    aluop_t   aluop;
    opcode_t  opcode;
    logic     bne;
    logic     alusrc;
    logic     regwr;
    logic     memwr;
    logic     memren;
    logic     memtoreg;
    logic     halt;
  } id_ex_t;

  typedef struct packed {
    word_t    result;
    word_t    store;
    word_t    target;
    regbits_t rd;
    opcode_t  opcode;
    logic     bne;
    logic     zero;
    logic     regwr;
    logic     memwr;
    logic     memren;
    logic     memtoreg;
    logic     halt;
  } ex_mem_t;

  typedef struct packed {
    word_t    result;
    word_t    dmemload;
    regbits_t rd;
    logic     regwr;
    logic     memtoreg;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: rtl/cpu_ifs.sv
// register file and hazard interfaces
`timescale 1ns/100ps
`default_nettype none

interface register_file_if import cpu_types_pkg::*; ();
  regbits_t rsel1, rsel2, wsel;
  word_t    rdat1, rdat2, wdat;
  logic     wen;

  modport rf (
    input  rsel1, rsel2, wsel, wdat, wen,
    output rdat1, rdat2
  );

  modport dp (
    output rsel1, rsel2, wsel, wdat, wen,
    input  rdat1, rdat2
  );
endinterface

interface hazard_unit_if import cpu_types_pkg::*; ();
  regbits_t id_ex_rs1, id_ex_rs2, ex_mem_rd, mem_wb_rd;
  logic     ex_mem_regwr, mem_wb_regwr, ex_mem_memren;
  logic     branch_taken, ihit, dhit;
  fwd_sel_t fwd_a, fwd_b;
  logic     stall, flush;

  modport hu (
    input  id_ex_rs1, id_ex_rs2, ex_mem_rd, mem_wb_rd,
    input  ex_mem_regwr, mem_wb_regwr, ex_mem_memren,
    input  branch_taken, ihit, dhit,
    output fwd_a, fwd_b, stall, flush
  );

  modport dp (
    output id_ex_rs1, id_ex_rs2, ex_mem_rd, mem_wb_rd,
    output ex_mem_regwr, mem_wb_regwr, ex_mem_memren,
    output branch_taken, ihit, dhit,
    input  fwd_a, fwd_b, stall, flush
  );
endinterface

`default_nettype wire

// File: rtl/control_unit.sv
// instruction decoder
`timescale 1ns/100ps
`default_nettype none

module control_unit import cpu_types_pkg::*; (
  input  word_t    i_ins,
  output regbits_t o_rs1,
  output regbits_t o_rs2,
  output regbits_t o_rd,
  output word_t    o_imm,
  output aluop_t   o_aluop,
  output logic     o_alusrc,
  output logic     o_regwr,
  output logic     o_memwr,
  output logic     o_memren,
  output logic     o_memtoreg,
  output logic     o_halt
);

  opcode_t    opcode;
  logic [2:0] funct3;

  assign opcode = opcode_t'(i_ins[6:0]);
  assign funct3 = i_ins[14:12];
  assign o_rd   = i_ins[11:7];
  assign o_halt = &i_ins;

  always_comb
  begin
    // unknown encodings fall through as a no-op
    o_rs1      = i_ins[19:15];
    o_rs2      = '0;
    o_imm      = {{20{i_ins[31]}}, i_ins[31:20]};
    o_aluop    = ALU_ADD;
    o_alusrc   = 1'b0;
    o_regwr    = 1'b0;
    o_memwr    = 1'b0;
    o_memren   = 1'b0;
    o_memtoreg = 1'b0;
    case (opcode)
      OP_OP:
      begin
        o_rs2   = i_ins[24:20];
        o_regwr = 1'b1;
        case (funct3)
          3'b000:  o_aluop = i_ins[30] ? ALU_SUB : ALU_ADD;
          3'b010:  o_aluop = ALU_SLT;
          3'b100:  o_aluop = ALU_XOR;
          3'b110:  o_aluop = ALU_OR;
          3'b111:  o_aluop = ALU_AND;
          default: o_regwr = 1'b0;
        endcase
      end
      OP_OPIMM:
      begin
        o_alusrc = 1'b1;
        o_regwr  = (funct3 == 3'b000);
      end
      OP_LOAD:
      begin
        o_alusrc   = 1'b1;
        o_memren   = (funct3 == 3'b010);
        o_memtoreg = o_memren;
        o_regwr    = o_memren;
      end
      OP_STORE:
      begin
        o_rs2    = i_ins[24:20];
        o_imm    = {{20{i_ins[31]}}, i_ins[31:25], i_ins[11:7]};
        o_alusrc = 1'b1;
        o_memwr  = (funct3 == 3'b010);
      end
      OP_BRANCH:
      begin
        // equality test through the zero flag
        o_rs2   = i_ins[24:20];
        o_imm   = {{19{i_ins[31]}}, i_ins[31], i_ins[7], i_ins[30:25], i_ins[11:8], 1'b0};
        o_aluop = ALU_SUB;
      end
      OP_JAL:
      begin
        o_rs1   = '0;
        o_imm   = {{11{i_ins[31]}}, i_ins[31], i_ins[19:12], i_ins[20], i_ins[30:21], 1'b0};
        o_regwr = 1'b1;
      end
      OP_JALR:
      begin
        o_alusrc = 1'b1;
        o_regwr  = 1'b1;
      end
      OP_LUI:
      begin
        // x0 + upper immediate
        o_rs1    = '0;
        o_imm    = {i_ins[31:12], 12'h000};
        o_alusrc = 1'b1;
        o_regwr  = 1'b1;
      end
      default:
      begin
        o_rs1 = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// integer register file
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module register_file import cpu_types_pkg::*; (
  input logic           CLK,
  input logic           nRST,
  register_file_if.rf   rf
);

  word_t regs [`REG_CNT];

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < `REG_CNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (rf.wen && rf.wsel != '0)
    begin
      regs[rf.wsel] <= rf.wdat;
    end
  end

  // x0 always reads zero
  assign rf.rdat1 = (rf.rsel1 == '0) ? '0 : regs[rf.rsel1];
  assign rf.rdat2 = (rf.rsel2 == '0) ? '0 : regs[rf.rsel2];

endmodule

`default_nettype wire

// File: rtl/alu.sv
// arithmetic logic unit
`timescale 1ns/100ps
`default_nettype none

module alu import cpu_types_pkg::*; (
  input  word_t  i_a,
  input  word_t  i_b,
  input  aluop_t i_op,
  output word_t  o_result,
  output logic   o_zero
);

  always_comb
  begin
    case (i_op)
      ALU_SUB: o_result = i_a - i_b;
      ALU_AND: o_result = i_a & i_b;
      ALU_OR:  o_result = i_a | i_b;
      ALU_XOR: o_result = i_a ^ i_b;
      ALU_SLT: o_result = word_t'($signed(i_a) < $signed(i_b));
      default: o_result = i_a + i_b;
    endcase
  end

  assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
// forwarding, stall and flush control
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import cpu_types_pkg::*; (
  hazard_unit_if.hu hu
);

  logic load_match;

  // nearest producer wins
  function automatic fwd_sel_t pick_src(input regbits_t src);
    fwd_sel_t sel;
    sel = FWD_RF;
    if (src != '0 && hu.ex_mem_regwr && hu.ex_mem_rd == src)
    begin
      sel = FWD_MEM;
    end
    else if (src != '0 && hu.mem_wb_regwr && hu.mem_wb_rd == src)
    begin
      sel = FWD_WB;
    end
    return sel;
  endfunction

  assign hu.fwd_a = pick_src(hu.id_ex_rs1);
  assign hu.fwd_b = pick_src(hu.id_ex_rs2);

  assign load_match = hu.ex_mem_rd != '0 &&
                      (hu.ex_mem_rd == hu.id_ex_rs1 || hu.ex_mem_rd == hu.id_ex_rs2);

  // hold execute until the load data arrives
  assign hu.stall = hu.ex_mem_memren && load_match && !hu.dhit;

  // redirect only on an accepted fetch cycle
  assign hu.flush = hu.branch_taken && hu.ihit;

endmodule

`default_nettype wire

// File: rtl/datapath.sv
// five stage pipelined core
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module datapath import cpu_types_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  output word_t o_imemaddr,
  input  word_t i_imemload,
  input  logic  i_ihit,
  output word_t o_dmemaddr,
  output word_t o_dmemstore,
  output logic  o_dmemren,
  output logic  o_dmemwen,
  input  word_t i_dmemload,
  input  logic  i_dhit,
  output logic  o_halt
);

  register_file_if rfif ();
  hazard_unit_if   hzif ();

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  word_t    pc, rdat1_id, rdat2_id, cu_imm;
  word_t    alu_a, alu_b, alu_out, rs2_val, ex_result, ex_target, mem_fwd, wb_val;
  regbits_t cu_rs1, cu_rs2, cu_rd;
  aluop_t   cu_aluop;
  logic     cu_alusrc, cu_regwr, cu_memwr, cu_memren, cu_memtoreg, cu_halt;
  logic     alu_zero, br_taken, halt_q, freeze, advance;

  control_unit cu0 (
    .i_ins(if_id.ins), .o_rs1(cu_rs1), .o_rs2(cu_rs2), .o_rd(cu_rd), .o_imm(cu_imm),
    .o_aluop(cu_aluop), .o_alusrc(cu_alusrc), .o_regwr(cu_regwr), .o_memwr(cu_memwr),
    .o_memren(cu_memren), .o_memtoreg(cu_memtoreg), .o_halt(cu_halt)
  );
  register_file rf0 (.CLK(CLK), .nRST(nRST), .rf(rfif));
  alu alu0 (.i_a(alu_a), .i_b(alu_b), .i_op(id_ex.aluop), .o_result(alu_out), .o_zero(alu_zero));
  hazard_unit hu0 (.hu(hzif));

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val);
    word_t val;
    case (sel)
      FWD_MEM: val = mem_fwd;
      FWD_WB:  val = wb_val;
      default: val = rf_val;
    endcase
    return val;
  endfunction

  assign o_imemaddr = pc;
  assign freeze     = halt_q || ex_mem.halt;
  assign advance    = i_ihit && !hzif.stall && !freeze;

  // decode, with bypass of a same-cycle writeback
  assign rfif.rsel1 = cu_rs1;
  assign rfif.rsel2 = cu_rs2;
  assign rdat1_id = (rfif.wen && cu_rs1 != '0 && rfif.wsel == cu_rs1) ? wb_val : rfif.rdat1;
  assign rdat2_id = (rfif.wen && cu_rs2 != '0 && rfif.wsel == cu_rs2) ? wb_val : rfif.rdat2;

  // execute
  assign alu_a     = fwd_mux(hzif.fwd_a, id_ex.rdat1);
  assign rs2_val   = fwd_mux(hzif.fwd_b, id_ex.rdat2);
  assign alu_b     = id_ex.alusrc ? id_ex.imm : rs2_val;
  assign ex_result = (id_ex.opcode == OP_JAL || id_ex.opcode == OP_JALR) ? id_ex.pc + 4 : alu_out;
  assign ex_target = (id_ex.opcode == OP_JALR) ? (alu_out & ~word_t'(1)) : id_ex.pc + id_ex.imm;

  // memory stage, load data is the result once dhit arrives
  assign mem_fwd     = ex_mem.memren ? i_dmemload : ex_mem.result;
  assign o_dmemaddr  = ex_mem.result;
  assign o_dmemstore = ex_mem.store;
  assign o_dmemren   = ex_mem.memren;
  assign o_dmemwen   = ex_mem.memwr;

  always_comb
  begin
    case (ex_mem.opcode)
      OP_BRANCH:       br_taken = ex_mem.zero ^ ex_mem.bne;
      OP_JAL, OP_JALR: br_taken = 1'b1;
      default:         br_taken = 1'b0;
    endcase
  end

  // writeback
  assign wb_val     = mem_wb.memtoreg ? mem_wb.dmemload : mem_wb.result;
  assign rfif.wsel  = mem_wb.rd;
  assign rfif.wdat  = wb_val;
  assign rfif.wen   = mem_wb.regwr;

  assign hzif.id_ex_rs1     = id_ex.rs1;
  assign hzif.id_ex_rs2     = id_ex.rs2;
  assign hzif.ex_mem_rd     = ex_mem.rd;
  assign hzif.mem_wb_rd     = mem_wb.rd;
  assign hzif.ex_mem_regwr  = ex_mem.regwr;
  assign hzif.mem_wb_regwr  = mem_wb.regwr;
  assign hzif.ex_mem_memren = ex_mem.memren;
  assign hzif.branch_taken  = br_taken;
  assign hzif.ihit          = i_ihit;
  assign hzif.dhit          = i_dhit;

  assign o_halt = halt_q;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      pc <= `PC_INIT;
    else if (hzif.flush)
      pc <= ex_mem.target;
    else if (advance)
      pc <= pc + 4;
  end

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      if_id  <= '0;
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
      halt_q <= 1'b0;
    end
    else
    begin
      if (ex_mem.halt)
        halt_q <= 1'b1;
      if (hzif.flush || freeze)
      begin
        if_id  <= '0;
        id_ex  <= '0;
        ex_mem <= '0;
      end
      else if (advance)
      begin
        if_id.pc  <= pc;
        if_id.ins <= i_imemload;

        id_ex.pc       <= if_id.pc;
        id_ex.rdat1    <= rdat1_id;
        id_ex.rdat2    <= rdat2_id;
        id_ex.imm      <= cu_imm;
        id_ex.rs1      <= cu_rs1;
        id_ex.rs2      <= cu_rs2;
        id_ex.rd       <= cu_rd;
        id_ex.aluop    <= cu_aluop;
        id_ex.opcode   <= opcode_t'(if_id.ins[6:0]);
        id_ex.bne      <= if_id.ins[12];
        id_ex.alusrc   <= cu_alusrc;
        id_ex.regwr    <= cu_regwr;
        id_ex.memwr    <= cu_memwr;
        id_ex.memren   <= cu_memren;
        id_ex.memtoreg <= cu_memtoreg;
        id_ex.halt     <= cu_halt;

        ex_mem.result   <= ex_result;
        ex_mem.store    <= rs2_val;
        ex_mem.target   <= ex_target;
        ex_mem.rd       <= id_ex.rd;
        ex_mem.opcode   <= id_ex.opcode;
        ex_mem.bne      <= id_ex.bne;
        ex_mem.zero     <= alu_zero;
        ex_mem.regwr    <= id_ex.regwr;
        ex_mem.memwr    <= id_ex.memwr;
        ex_mem.memren   <= id_ex.memren;
        ex_mem.memtoreg <= id_ex.memtoreg;
        ex_mem.halt     <= id_ex.halt;
      end
      else if (i_dhit)
      begin
        // capture forwarded operands before the producers move on
        id_ex.rdat1 <= alu_a;
        id_ex.rdat2 <= rs2_val;
        ex_mem      <= '0;
      end

      if (i_ihit || i_dhit)
      begin
        mem_wb.result   <= ex_mem.result;
        mem_wb.dmemload <= i_dmemload;
        mem_wb.rd       <= ex_mem.rd;
        mem_wb.regwr    <= ex_mem.regwr;
        mem_wb.memtoreg <= ex_mem.memtoreg;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/datapath_assertions.sv
// core protocol assertions
`timescale 1ns/100ps
`default_nettype none

module datapath_assertions import cpu_types_pkg::*; (
  input logic  CLK,
  input logic  nRST,
  input word_t i_imemaddr,
  input word_t i_dmemaddr,
  input logic  i_dmemren,
  input logic  i_dmemwen,
  input logic  i_halt
);

  int fail_cnt = 0;

  a_one_access: assert property (@(posedge CLK) disable iff (!nRST)
    !(i_dmemren && i_dmemwen))
  else
  begin
    $error("read and write strobes high together");
    fail_cnt++;
  end

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) i_halt |=> i_halt)
  else
  begin
    $error("halt dropped before reset");
    fail_cnt++;
  end

  a_pc_frozen: assert property (@(posedge CLK) disable iff (!nRST)
    i_halt |=> $stable(i_imemaddr))
  else
  begin
    $error("fetch address moved after halt");
    fail_cnt++;
  end

  // word accesses only
  a_aligned: assert property (@(posedge CLK) disable iff (!nRST)
    (i_dmemren || i_dmemwen) |-> i_dmemaddr[1:0] == 2'b00)
  else
  begin
    $error("unaligned data address %h", i_dmemaddr);
    fail_cnt++;
  end

  a_reset_quiet: assert property (@(posedge CLK)
    !nRST |-> !i_dmemren && !i_dmemwen && !i_halt)
  else
  begin
    $error("control outputs active during reset");
    fail_cnt++;
  end

endmodule

bind datapath datapath_assertions u_assert (
  .CLK(CLK),
  .nRST(nRST),
  .i_imemaddr(o_imemaddr),
  .i_dmemaddr(o_dmemaddr),
  .i_dmemren(o_dmemren),
  .i_dmemwen(o_dmemwen),
  .i_halt(o_halt)
);

`default_nettype wire

// File: testbench/datapath_tb.sv
// pipelined core testbench
`timescale 1ns/100ps
`default_nettype none

module datapath_tb import cpu_types_pkg::*; ();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_TESTS    = 5;
  localparam int CPI_BOUND    = 16;
  localparam word_t HALT_INS  = 32'hFFFF_FFFF;

  logic  CLK = 1'b0;
  logic  nRST = 1'b0;
  word_t i_imemload = '0;
  word_t i_dmemload = '0;
  logic  i_ihit = 1'b0;
  logic  i_dhit = 1'b0;
  word_t o_imemaddr, o_dmemaddr, o_dmemstore;
  logic  o_dmemren, o_dmemwen, o_halt;

  word_t imem [256];
  word_t dmem [256];
  word_t prog [$];
  word_t exp_addr [$];
  word_t exp_data [$];

  integer seed = 32'h0204a63f;
  int     wait_cnt = 0;
  int     store_cnt = 0;
  int     errors = 0;
  int     passed = 0;
  int     failed = 0;
  int     total_ins = 0;
  longint wd_limit = 0;
  string  test_name;

  datapath dut0 (
    .CLK(CLK), .nRST(nRST),
    .o_imemaddr(o_imemaddr), .i_imemload(i_imemload), .i_ihit(i_ihit),
    .o_dmemaddr(o_dmemaddr), .o_dmemstore(o_dmemstore),
    .o_dmemren(o_dmemren), .o_dmemwen(o_dmemwen),
    .i_dmemload(i_dmemload), .i_dhit(i_dhit), .o_halt(o_halt)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // memory model fetches only while no data request is pending
  always @(negedge CLK)
  begin
    if (!nRST)
    begin
      i_ihit   <= 1'b0;
      i_dhit   <= 1'b0;
      wait_cnt = 0;
    end
    else if (o_dmemren || o_dmemwen)
    begin
      i_ihit <= 1'b0;
      if (wait_cnt == 0)
        wait_cnt = 1 + ({$random(seed)} % 3);
      wait_cnt = wait_cnt - 1;
      if (wait_cnt == 0)
      begin
        i_dhit     <= 1'b1;
        i_dmemload <= dmem[o_dmemaddr[9:2]];
        if (o_dmemwen)
        begin
          dmem[o_dmemaddr[9:2]] = o_dmemstore;
          check_store(o_dmemaddr, o_dmemstore);
        end
      end
      else
        i_dhit <= 1'b0;
    end
    else
    begin
      i_ihit     <= 1'b1;
      i_dhit     <= 1'b0;
      i_imemload <= imem[o_imemaddr[9:2]];
    end
  end

  // instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input regbits_t rs2,
                                  input regbits_t rs1, input logic [2:0] f3,
                                  input regbits_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_i(input int imm, input regbits_t rs1, input logic [2:0] f3,
                                  input regbits_t rd, input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input int imm, input regbits_t rs2, input regbits_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input int imm, input regbits_t rs2, input regbits_t rs1,
                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_j(input int imm, input regbits_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input regbits_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic emit(input word_t ins);
    prog.push_back(ins);
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic store_word(input regbits_t rs2, input int addr, input word_t data);
    emit(enc_s(addr, rs2, 0));
    expect_store(addr, data);
  endtask

  task automatic build_program(input int k);
    word_t a, b, c, d, e, f, g, h, m;
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    case (k)
      0:
      begin
        test_name = "arith_forwarding";
        a = 37;
        b = -5;
        emit(enc_i(37, 0, 3'b000, 1, OP_OPIMM));
        emit(enc_i(-5, 0, 3'b000, 2, OP_OPIMM));
        c = a + b;
        emit(enc_r(7'h00, 2, 1, 3'b000, 3));
        store_word(3, 'h100, c);
        d = c - a;
        emit(enc_r(7'h20, 1, 3, 3'b000, 4));
        store_word(4, 'h104, d);
        e = d & a;
        emit(enc_r(7'h00, 1, 4, 3'b111, 5));
        store_word(5, 'h108, e);
        f = e | b;
        emit(enc_r(7'h00, 2, 5, 3'b110, 6));
        store_word(6, 'h10C, f);
        g = f ^ a;
        emit(enc_r(7'h00, 1, 6, 3'b100, 7));
        store_word(7, 'h110, g);
        emit(enc_r(7'h00, 1, 2, 3'b010, 8));
        store_word(8, 'h114, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        emit(enc_r(7'h00, 2, 1, 3'b010, 9));
        store_word(9, 'h118, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        h = 32'hABCDE000;
        emit(enc_u(20'hABCDE, 10));
        store_word(10, 'h11C, h);
        m = h + 32'h123;
        emit(enc_i('h123, 10, 3'b000, 11, OP_OPIMM));
        store_word(11, 'h120, m);
        emit(enc_i(-1, 11, 3'b000, 12, OP_OPIMM));
        store_word(12, 'h124, m - 1);
      end
      1:
      begin
        test_name = "load_use";
        emit(enc_i(100, 0, 3'b000, 3, OP_OPIMM));
        emit(enc_i('h40, 0, 3'b010, 1, OP_LOAD));
        emit(enc_r(7'h00, 3, 1, 3'b000, 2));
        store_word(2, 'h130, dmem['h10] + 32'd100);
        emit(enc_i('h44, 0, 3'b010, 4, OP_LOAD));
        store_word(4, 'h134, dmem['h11]);
        emit(enc_i('h48, 0, 3'b010, 5, OP_LOAD));
        emit(enc_i(-1, 5, 3'b000, 6, OP_OPIMM));
        store_word(6, 'h138, dmem['h12] - 32'd1);
      end
      2:
      begin
        test_name = "branch_flush";
        emit(enc_i(5, 0, 3'b000, 1, OP_OPIMM));
        emit(enc_i(5, 0, 3'b000, 2, OP_OPIMM));
        emit(enc_i(9, 0, 3'b000, 3, OP_OPIMM));
        // taken beq skips two stores
        emit(enc_b(12, 2, 1, 3'b000));
        emit(enc_s('h140, 1, 0));
        emit(enc_s('h144, 2, 0));
        store_word(3, 'h148, 32'd9);
        emit(enc_b(8, 2, 1, 3'b001));
        store_word(3, 'h14C, 32'd9);
        emit(enc_b(8, 3, 1, 3'b001));
        emit(enc_s('h150, 1, 0));
        emit(enc_b(8, 3, 1, 3'b000));
        store_word(2, 'h154, 32'd5);
      end
      3:
      begin
        test_name = "jumps";
        emit(enc_j(12, 1));
        emit(enc_s('h160, 0, 0));
        emit(enc_s('h164, 0, 0));
        store_word(1, 'h168, 32'd0 + 32'd4);
        emit(enc_i(32, 0, 3'b000, 6, OP_OPIMM));
        // jalr at word 5 lands on word 10
        emit(enc_i(8, 6, 3'b000, 7, OP_JALR));
        for (int i = 0; i < 4; i++)
          emit(enc_s('h16C + 4 * i, 0, 0));
        store_word(7, 'h17C, 32'd20 + 32'd4);
      end
      default:
      begin
        test_name = "memory_latency";
        emit(enc_i('h55, 0, 3'b000, 1, OP_OPIMM));
        store_word(1, 'h180, 32'h55);
        emit(enc_i('h180, 0, 3'b010, 2, OP_LOAD));
        emit(enc_r(7'h00, 2, 2, 3'b000, 3));
        store_word(3, 'h184, 32'hAA);
        emit(enc_i('h184, 0, 3'b010, 4, OP_LOAD));
        store_word(4, 'h188, 32'hAA);
      end
    endcase
    emit(HALT_INS);
  endtask

  // compare a completed store with the next expected entry
  task automatic check_store(input word_t addr, input word_t data);
    if (store_cnt >= exp_addr.size())
    begin
      $display("test %s made an unexpected store to %h", test_name, addr);
      errors++;
    end
    else
    begin
      if (addr !== exp_addr[store_cnt])
      begin
        $display("ERROR %s store %0d o_dmemaddr expected %h got %h",
                 test_name, store_cnt, exp_addr[store_cnt], addr);
        errors++;
      end
      if (data !== exp_data[store_cnt])
      begin
        $display("ERROR %s store %0d o_dmemstore expected %h got %h",
                 test_name, store_cnt, exp_data[store_cnt], data);
        errors++;
      end
    end
    store_cnt++;
  endtask

  task automatic run_test(input int k);
    int errs_before;
    errs_before = errors;
    build_program(k);
    nRST <= 1'b0;
    for (int i = 0; i < 256; i++)
      imem[i] = {i[29:0], 2'b00};
    foreach (prog[i])
      imem[i] = prog[i];
    store_cnt = 0;
    repeat (RESET_CYCLES) @(negedge CLK);
    nRST <= 1'b1;
    while (!o_halt)
      @(negedge CLK);
    // halted core stays off the data port
    repeat (5)
    begin
      @(negedge CLK);
      if (o_dmemren || o_dmemwen)
      begin
        $display("test %s made a data access after halt", test_name);
        errors++;
      end
    end
    if (store_cnt != exp_addr.size())
    begin
      $display("test %s saw %0d stores where %0d were expected",
               test_name, store_cnt, exp_addr.size());
      errors++;
    end
    if (errors == errs_before)
    begin
      passed++;
      $display("test %s ok, %0d stores", test_name, store_cnt);
    end
    else
    begin
      failed++;
      $display("test %s failed with %0d errors", test_name, errors - errs_before);
    end
  endtask

  initial
  begin
    for (int i = 0; i < 256; i++)
      dmem[i] = $random(seed) ^ (i * 32'h9E37_79B9);
    for (int k = 0; k < NUM_TESTS; k++)
    begin
      build_program(k);
      total_ins += prog.size();
    end
    wd_limit = longint'(total_ins * CPI_BOUND + NUM_TESTS * (RESET_CYCLES + 10)) * CLK_PERIOD;
    for (int k = 0; k < NUM_TESTS; k++)
      run_test(k);
    errors += dut0.u_assert.fail_cnt;
    $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
             NUM_TESTS, passed, failed, errors, dut0.u_assert.fail_cnt);
    if (failed == 0 && errors == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    wait (wd_limit != 0);
    #(wd_limit);
    $display("watchdog expired while running test %s", test_name);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/cpu_types_pkg.sv
rtl/cpu_ifs.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/datapath.sv
testbench/datapath_assertions.sv
testbench/datapath_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= datapath_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Simulation FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
